// File: verilog/hit_consts.svh
`ifndef HIT_CONSTS_SVH
`define HIT_CONSTS_SVH

// Width of every fixed-point word.
`define HIT_WORD_W 32

// Fraction bits in a word.
`define HIT_FRAC_W 16

`endif

// File: verilog/hit_pkg.sv
`default_nettype none

`include "hit_consts.svh"

package hit_pkg;

  typedef logic signed [`HIT_WORD_W-1:0]   word_t;
  typedef logic signed [2*`HIT_WORD_W-1:0] dword_t;

  typedef struct packed {
    word_t x;
    word_t y;
    word_t z;
  } vec3_t;

  // Full-width products, before scaling.
  typedef struct packed {
    dword_t x;
    dword_t y;
    dword_t z;
  } prod3_t;

  typedef struct packed {
    vec3_t axis;
    logic  is_cylinder;
  } obj_t;

  // Drop the extra fraction bits and keep the low word.
  function automatic word_t fx_trunc(dword_t p);
    return word_t'(p >>> `HIT_FRAC_W);
  endfunction

endpackage

`default_nettype wire

// File: verilog/axis_delay.sv
`timescale 1ns/100ps
`default_nettype none

module axis_delay #(
  parameter int  LATENCY = 1,
  parameter type T       = logic
) (
  input  wire   aclk,
  input  wire   rst_n,
  input  wire T s_data,
  input  wire   s_valid,
  output logic  s_ready,
  output T      m_data,
  output logic  m_valid,
  input  wire   m_ready
);

  T                   data_q [LATENCY];
  logic [LATENCY-1:0] valid_q;
  logic [LATENCY-1:0] load;

  // A register loads when empty or when the one after it moves on.
  always_comb begin
    load[LATENCY-1] = !valid_q[LATENCY-1] || m_ready;
    for (int i = LATENCY - 2; i >= 0; i--) begin
      load[i] = !valid_q[i] || load[i+1];
    end
  end

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      valid_q <= '0;
    end else begin
      if (load[0]) begin
        valid_q[0] <= s_valid;
      end
      for (int i = 1; i < LATENCY; i++) begin
        if (load[i]) begin
          valid_q[i] <= valid_q[i-1];
        end
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (load[0] && s_valid) begin
      data_q[0] <= s_data;
    end
    for (int i = 1; i < LATENCY; i++) begin
      if (load[i] && valid_q[i-1]) begin
        data_q[i] <= data_q[i-1];
      end
    end
  end

  assign s_ready = load[0];
  assign m_data  = data_q[LATENCY-1];
  assign m_valid = valid_q[LATENCY-1];

endmodule

`default_nettype wire

// File: verilog/vec_fma.sv
`timescale 1ns/100ps
`default_nettype none

module vec_fma import hit_pkg::*; (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire vec3_t a_data,
  input  wire word_t s_data,
  input  wire vec3_t c_data,
  input  wire        in_valid,
  output logic       in_ready,
  output vec3_t      m_data,
  output logic       m_valid,
  input  wire        m_ready
);

  prod3_t prod_q;
  vec3_t  c1_q;
  vec3_t  scaled_q;
  vec3_t  c2_q;
  vec3_t  sum_q;
  logic   v1_q;
  logic   v2_q;
  logic   v3_q;
  logic   en1;
  logic   en2;
  logic   en3;

  assign en3      = !v3_q || m_ready;
  assign en2      = !v2_q || en3;
  assign en1      = !v1_q || en2;
  assign in_ready = en1;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
      v3_q <= 1'b0;
    end else begin
      if (en1) begin
        v1_q <= in_valid;
      end
      if (en2) begin
        v2_q <= v1_q;
      end
      if (en3) begin
        v3_q <= v2_q;
      end
    end
  end

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Multiply, scale, then add c.
  always_ff @(posedge aclk) begin
    if (en1 && in_valid) begin
      prod_q.x <= dword_t'(a_data.x) * dword_t'(s_data);
      prod_q.y <= dword_t'(a_data.y) * dword_t'(s_data);
      prod_q.z <= dword_t'(a_data.z) * dword_t'(s_data);
      c1_q     <= c_data;
    end
    if (en2 && v1_q) begin
      scaled_q.x <= fx_trunc(prod_q.x);
      scaled_q.y <= fx_trunc(prod_q.y);
      scaled_q.z <= fx_trunc(prod_q.z);
      c2_q       <= c1_q;
    end
    if (en3 && v2_q) begin
      sum_q.x <= scaled_q.x + c2_q.x;
      sum_q.y <= scaled_q.y + c2_q.y;
      sum_q.z <= scaled_q.z + c2_q.z;
    end
  end

  assign m_data  = sum_q;
  assign m_valid = v3_q;

endmodule

`default_nettype wire

// File: verilog/vec_add.sv
`timescale 1ns/100ps
`default_nettype none

module vec_add import hit_pkg::*; #(
  parameter bit SUBTRACT = 1'b0
) (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire vec3_t a_data,
  input  wire        a_valid,
  output logic       a_ready,
  input  wire vec3_t b_data,
  input  wire        b_valid,
  output logic       b_ready,
  output vec3_t      m_data,
  output logic       m_valid,
  input  wire        m_ready
);

  vec3_t sum_q;
  logic  v_q;
  logic  en;
  logic  take;

  assign en   = !v_q || m_ready;
  // Both inputs move together, or neither does.
  assign take    = en && a_valid && b_valid;
  assign a_ready = take;
  assign b_ready = take;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      v_q <= 1'b0;
    end else if (en) begin
      v_q <= a_valid && b_valid;
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      sum_q.x <= SUBTRACT ? a_data.x - b_data.x : a_data.x + b_data.x;
      sum_q.y <= SUBTRACT ? a_data.y - b_data.y : a_data.y + b_data.y;
      sum_q.z <= SUBTRACT ? a_data.z - b_data.z : a_data.z + b_data.z;
    end
  end

  assign m_data  = sum_q;
  assign m_valid = v_q;

endmodule

`default_nettype wire

// File: verilog/vec_dot.sv
`timescale 1ns/100ps
`default_nettype none

module vec_dot import hit_pkg::*; (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire vec3_t a_data,
  input  wire        a_valid,
  output logic       a_ready,
  input  wire vec3_t b_data,
  input  wire        b_valid,
  output logic       b_ready,
  output word_t      m_data,
  output logic       m_valid,
  input  wire        m_ready
);

  vec3_t prod_q;
  word_t sum_xy_q;
  word_t z2_q;
  word_t dot_q;
  logic  v1_q;
  logic  v2_q;
  logic  v3_q;
  logic  en1;
  logic  en2;
  logic  en3;
  logic  take;

  assign en3     = !v3_q || m_ready;
  assign en2     = !v2_q || en3;
  assign en1     = !v1_q || en2;
  assign take    = en1 && a_valid && b_valid;
  assign a_ready = take;
  assign b_ready = take;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
      v3_q <= 1'b0;
    end else begin
      if (en1) begin
        v1_q <= a_valid && b_valid;
      end
      if (en2) begin
        v2_q <= v1_q;
      end
      if (en3) begin
        v3_q <= v2_q;
      end
    end
  end

  // Each product is scaled before the adds.
  always_ff @(posedge aclk) begin
    if (take) begin
      prod_q.x <= fx_trunc(dword_t'(a_data.x) * dword_t'(b_data.x));
      prod_q.y <= fx_trunc(dword_t'(a_data.y) * dword_t'(b_data.y));
      prod_q.z <= fx_trunc(dword_t'(a_data.z) * dword_t'(b_data.z));
    end
    if (en2 && v1_q) begin
      sum_xy_q <= prod_q.x + prod_q.y;
      z2_q     <= prod_q.z;
    end
    if (en3 && v2_q) begin
      dot_q <= sum_xy_q + z2_q;
    end
  end

  assign m_data  = dot_q;
  assign m_valid = v3_q;

endmodule

`default_nettype wire

// File: verilog/vec_scale.sv
`timescale 1ns/100ps
`default_nettype none

module vec_scale import hit_pkg::*; (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire obj_t  v_data,
  input  wire        v_valid,
  output logic       v_ready,
  input  wire word_t s_data,
  input  wire        s_valid,
  output logic       s_ready,
  output vec3_t      m_data,
  output logic       m_valid,
  input  wire        m_ready
);

  prod3_t prod_q;
  logic   cyl_q;
  vec3_t  res_q;
  logic   v1_q;
  logic   v2_q;
  logic   en1;
  logic   en2;
  logic   take;

  assign en2     = !v2_q || m_ready;
  assign en1     = !v1_q || en2;
  assign take    = en1 && v_valid && s_valid;
  assign v_ready = take;
  assign s_ready = take;

  always_ff @(posedge aclk) begin
    if (!rst_n) begin
      v1_q <= 1'b0;
      v2_q <= 1'b0;
    end else begin
      if (en1) begin
        v1_q <= v_valid && s_valid;
      end
      if (en2) begin
        v2_q <= v1_q;
      end
    end
  end

  always_ff @(posedge aclk) begin
    if (take) begin
      prod_q.x <= dword_t'(v_data.axis.x) * dword_t'(s_data);
      prod_q.y <= dword_t'(v_data.axis.y) * dword_t'(s_data);
      prod_q.z <= dword_t'(v_data.axis.z) * dword_t'(s_data);
      cyl_q    <= v_data.is_cylinder;
    end
    // Spheres get no axial correction.
    if (en2 && v1_q) begin
      res_q.x <= cyl_q ? fx_trunc(prod_q.x) : '0;
      res_q.y <= cyl_q ? fx_trunc(prod_q.y) : '0;
      res_q.z <= cyl_q ? fx_trunc(prod_q.z) : '0;
    end
  end

  assign m_data  = res_q;
  assign m_valid = v2_q;

endmodule

`default_nettype wire

// File: verilog/hit_point.sv
`timescale 1ns/100ps
`default_nettype none

module hit_point import hit_pkg::*; (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire vec3_t obj_center,
  input  wire vec3_t obj_axis,
  input  wire        obj_is_cylinder,
  input  wire        obj_valid,
  output logic       obj_ready,
  input  wire word_t t_data,
  input  wire        t_valid,
  output logic       t_ready,
  input  wire vec3_t ray_origin,
  input  wire vec3_t ray_dir,
  input  wire        ray_valid,
  output logic       ray_ready,
  output vec3_t      hit_point_data,
  output logic       hit_point_valid,
  input  wire        hit_point_ready,
  output vec3_t      normal_data,
  output logic       normal_valid,
  input  wire        normal_ready
);

  // Delays that line each operand up with its partner.
  localparam int C_LAT      = 3;
  localparam int A_DOT_LAT  = 4;
  localparam int A_SCL_LAT  = 7;
  localparam int D_LAT      = 5;
  localparam int P_LAT      = 7;

  obj_t  obj_in;
  logic  all_valid;
  logic  dst_ready;
  logic  in_take;
  logic  fma_ready;
  logic  c_in_ready;
  logic  adot_in_ready;
  logic  ascl_in_ready;

  vec3_t p_data;
  logic  p_valid;
  logic  p_ready;
  logic  p_sub_valid;
  logic  p_sub_ready;
  logic  p_del_valid;
  logic  p_del_ready;

  vec3_t c_data;
  logic  c_valid;
  logic  c_ready;

  vec3_t d_data;
  logic  d_valid;
  logic  d_ready;
  logic  d_dot_valid;
  logic  d_dot_ready;
  logic  d_del_valid;
  logic  d_del_ready;

  vec3_t adot_data;
  logic  adot_valid;
  logic  adot_ready;
  obj_t  ascl_data;
  logic  ascl_valid;
  logic  ascl_ready;

  word_t k_data;
  logic  k_valid;
  logic  k_ready;
  vec3_t ak_data;
  logic  ak_valid;
  logic  ak_ready;
  vec3_t dd_data;
  logic  dd_valid;
  logic  dd_ready;

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Input join. One transaction needs all three streams and every consumer.
  assign obj_in.axis        = obj_axis;
  assign obj_in.is_cylinder = obj_is_cylinder;

  assign all_valid = obj_valid && t_valid && ray_valid;
  assign dst_ready = fma_ready && c_in_ready && adot_in_ready && ascl_in_ready;
  assign in_take   = all_valid && dst_ready;
  assign obj_ready = in_take;
  assign t_ready   = in_take;
  assign ray_ready = in_take;

  vec_fma i_fma (
    .aclk     (aclk),
    .rst_n    (rst_n),
    .a_data   (ray_dir),
    .s_data   (t_data),
    .c_data   (ray_origin),
    .in_valid (in_take),
    .in_ready (fma_ready),
    .m_data   (p_data),
    .m_valid  (p_valid),
    .m_ready  (p_ready)
  );

  axis_delay #(.LATENCY(C_LAT), .T(vec3_t)) i_c_delay (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (obj_center),
    .s_valid (in_take),
    .s_ready (c_in_ready),
    .m_data  (c_data),
    .m_valid (c_valid),
    .m_ready (c_ready)
  );

  axis_delay #(.LATENCY(A_DOT_LAT), .T(vec3_t)) i_a_dot_delay (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (obj_axis),
    .s_valid (in_take),
    .s_ready (adot_in_ready),
    .m_data  (adot_data),
    .m_valid (adot_valid),
    .m_ready (adot_ready)
  );

  axis_delay #(.LATENCY(A_SCL_LAT), .T(obj_t)) i_a_scl_delay (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (obj_in),
    .s_valid (in_take),
    .s_ready (ascl_in_ready),
    .m_data  (ascl_data),
    .m_valid (ascl_valid),
    .m_ready (ascl_ready)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Fork of P. Each branch sees valid only when the other branch can take it.
  assign p_sub_valid = p_valid && p_del_ready;
  assign p_del_valid = p_valid && p_sub_ready;
  assign p_ready     = p_sub_ready && p_del_ready;

  vec_add #(.SUBTRACT(1'b1)) i_sub_center (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .a_data  (p_data),
    .a_valid (p_sub_valid),
    .a_ready (p_sub_ready),
    .b_data  (c_data),
    .b_valid (c_valid),
    .b_ready (c_ready),
    .m_data  (d_data),
    .m_valid (d_valid),
    .m_ready (d_ready)
  );

  axis_delay #(.LATENCY(P_LAT), .T(vec3_t)) i_p_delay (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (p_data),
    .s_valid (p_del_valid),
    .s_ready (p_del_ready),
    .m_data  (hit_point_data),
    .m_valid (hit_point_valid),
    .m_ready (hit_point_ready)
  );

  // Fork of D = P - C.
  assign d_dot_valid = d_valid && d_del_ready;
  assign d_del_valid = d_valid && d_dot_ready;
  assign d_ready     = d_dot_ready && d_del_ready;

  vec_dot i_dot (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .a_data  (d_data),
    .a_valid (d_dot_valid),
    .a_ready (d_dot_ready),
    .b_data  (adot_data),
    .b_valid (adot_valid),
    .b_ready (adot_ready),
    .m_data  (k_data),
    .m_valid (k_valid),
    .m_ready (k_ready)
  );

  axis_delay #(.LATENCY(D_LAT), .T(vec3_t)) i_d_delay (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .s_data  (d_data),
    .s_valid (d_del_valid),
    .s_ready (d_del_ready),
    .m_data  (dd_data),
    .m_valid (dd_valid),
    .m_ready (dd_ready)
  );

  vec_scale i_scale (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .v_data  (ascl_data),
    .v_valid (ascl_valid),
    .v_ready (ascl_ready),
    .s_data  (k_data),
    .s_valid (k_valid),
    .s_ready (k_ready),
    .m_data  (ak_data),
    .m_valid (ak_valid),
    .m_ready (ak_ready)
  );

  // N = D - A * (D . A).
  vec_add #(.SUBTRACT(1'b1)) i_sub_axial (
    .aclk    (aclk),
    .rst_n   (rst_n),
    .a_data  (dd_data),
    .a_valid (dd_valid),
    .a_ready (dd_ready),
    .b_data  (ak_data),
    .b_valid (ak_valid),
    .b_ready (ak_ready),
    .m_data  (normal_data),
    .m_valid (normal_valid),
    .m_ready (normal_ready)
  );

endmodule

`default_nettype wire

// File: verif/hit_point_checker.sv
`timescale 1ns/100ps
`default_nettype none

module hit_point_checker import hit_pkg::*; (
  input  wire        aclk,
  input  wire        rst_n,
  input  wire        strict_latency,
  input  wire        exp_valid,
  input  wire vec3_t exp_point,
  input  wire vec3_t exp_normal,
  input  wire vec3_t hit_point_data,
  input  wire        hit_point_valid,
  input  wire        hit_point_ready,
  input  wire vec3_t normal_data,
  input  wire        normal_valid,
  input  wire        normal_ready,
  output int         err_count,
  output int         point_count,
  output int         normal_count,
  output int         pending
);

  localparam int LATENCY = 10;

  vec3_t point_q [$];
  vec3_t normal_q [$];
  int    point_stamp_q [$];
  int    normal_stamp_q [$];
  int    cyc = 0;
  int    errors = 0;
  int    points = 0;
  int    normals = 0;
  bit    any_accept = 1'b0;

  task automatic check_word(string field, word_t exp_w, word_t act_w);
    if (act_w !== exp_w) begin
      $display("ERR %0t: %s expected %h got %h", $time, field, exp_w, act_w);
      errors++;
    end
  endtask

  task automatic check_vec(string name, vec3_t exp_v, vec3_t act_v);
    check_word({name, ".x"}, exp_v.x, act_v.x);
    check_word({name, ".y"}, exp_v.y, act_v.y);
    check_word({name, ".z"}, exp_v.z, act_v.z);
  endtask

  // Stamps hold the cycle of input acceptance.
  task automatic check_latency(string name, int stamp);
    if (strict_latency && cyc - stamp != LATENCY) begin
      $display("ERR %0t: %s latency expected %0d got %0d", $time, name, LATENCY, cyc - stamp);
      errors++;
    end
  endtask

  always @(posedge aclk) begin
    cyc = cyc + 1;
    if (rst_n) begin
      // The model result shows up one cycle after acceptance.
      if (exp_valid) begin
        any_accept = 1'b1;
        point_q.push_back(exp_point);
        point_stamp_q.push_back(cyc - 1);
        normal_q.push_back(exp_normal);
        normal_stamp_q.push_back(cyc - 1);
      end
      if (!any_accept && (hit_point_valid || normal_valid)) begin
        $display("ERR %0t: output valid before any input was accepted", $time);
        errors++;
      end
      if (hit_point_valid && hit_point_ready) begin
        if (point_q.size() == 0) begin
          $display("A hit point came out with no transaction outstanding at %0t", $time);
          errors++;
        end else begin
          check_vec("hit_point", point_q.pop_front(), hit_point_data);
          check_latency("hit_point", point_stamp_q.pop_front());
          points++;
        end
      end
      if (normal_valid && normal_ready) begin
        if (normal_q.size() == 0) begin
          $display("A normal came out with no transaction outstanding at %0t", $time);
          errors++;
        end else begin
          check_vec("normal", normal_q.pop_front(), normal_data);
          check_latency("normal", normal_stamp_q.pop_front());
          normals++;
        end
      end
    end
    err_count    <= errors;
    point_count  <= points;
    normal_count <= normals;
    pending      <= point_q.size() + normal_q.size();
  end

endmodule

`default_nettype wire

// File: verif/tb_hit_point.sv
`timescale 1ns/100ps
`default_nettype none

`include "hit_consts.svh"

module tb_hit_point import hit_pkg::*; ();

  localparam int ISOLATED   = 8;
  localparam int BURST      = 50;
  localparam int RANDOM     = 400;
  localparam int WAIT_LIMIT = 20000;

  logic        aclk = 1'b0;
  logic        rst_n = 1'b0;
  vec3_t       obj_center = '0;
  vec3_t       obj_axis = '0;
  logic        obj_is_cylinder = 1'b0;
  logic        obj_valid = 1'b0;
  logic        obj_ready;
  word_t       t_data = '0;
  logic        t_valid = 1'b0;
  logic        t_ready;
  vec3_t       ray_origin = '0;
  vec3_t       ray_dir = '0;
  logic        ray_valid = 1'b0;
  logic        ray_ready;
  vec3_t       hit_point_data;
  logic        hit_point_valid;
  logic        hit_point_ready = 1'b0;
  vec3_t       normal_data;
  logic        normal_valid;
  logic        normal_ready = 1'b0;

  logic [31:0] rng_state = 32'h2ed8_d133;
  int          target = 0;
  int          n_accept = 0;
  int          obj_sent = 0;
  int          t_sent = 0;
  int          ray_sent = 0;
  bit          rand_valid = 1'b0;
  bit          rand_ready = 1'b0;
  bit          strict_latency = 1'b0;
  bit          burst_check = 1'b0;
  bit          aborted = 1'b0;
  int          input_errors = 0;
  logic        exp_valid = 1'b0;
  vec3_t       exp_point = '0;
  vec3_t       exp_normal = '0;
  int          err_count;
  int          point_count;
  int          normal_count;
  int          pending;

  always #5 aclk = ~aclk;

  hit_point i_dut (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .obj_center      (obj_center),
    .obj_axis        (obj_axis),
    .obj_is_cylinder (obj_is_cylinder),
    .obj_valid       (obj_valid),
    .obj_ready       (obj_ready),
    .t_data          (t_data),
    .t_valid         (t_valid),
    .t_ready         (t_ready),
    .ray_origin      (ray_origin),
    .ray_dir         (ray_dir),
    .ray_valid       (ray_valid),
    .ray_ready       (ray_ready),
    .hit_point_data  (hit_point_data),
    .hit_point_valid (hit_point_valid),
    .hit_point_ready (hit_point_ready),
    .normal_data     (normal_data),
    .normal_valid    (normal_valid),
    .normal_ready    (normal_ready)
  );

  hit_point_checker i_checker (
    .aclk            (aclk),
    .rst_n           (rst_n),
    .strict_latency  (strict_latency),
    .exp_valid       (exp_valid),
    .exp_point       (exp_point),
    .exp_normal      (exp_normal),
    .hit_point_data  (hit_point_data),
    .hit_point_valid (hit_point_valid),
    .hit_point_ready (hit_point_ready),
    .normal_data     (normal_data),
    .normal_valid    (normal_valid),
    .normal_ready    (normal_ready),
    .err_count       (err_count),
    .point_count     (point_count),
    .normal_count    (normal_count),
    .pending         (pending)
  );

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Random source and reference model.
  function automatic logic [31:0] next_rand();
    rng_state = rng_state ^ (rng_state << 13);
    rng_state = rng_state ^ (rng_state >> 17);
    rng_state = rng_state ^ (rng_state << 5);
    return rng_state;
  endfunction

  function automatic bit chance(int pct);
    return (next_rand() % 100) < 32'(pct);
  endfunction

  // Signed value of the low bits; 24 bits span +-128.0, 17 bits +-1.0.
  function automatic word_t rand_word(int bits);
    word_t w;
    w = next_rand();
    w = w <<< (32 - bits);
    return w >>> (32 - bits);
  endfunction

  function automatic vec3_t rand_vec(int bits);
    vec3_t v;
    v.x = rand_word(bits);
    v.y = rand_word(bits);
    v.z = rand_word(bits);
    return v;
  endfunction

  function automatic word_t fx_mul(word_t a, word_t b);
    logic signed [2*`HIT_WORD_W-1:0] wa;
    logic signed [2*`HIT_WORD_W-1:0] wb;
    logic signed [2*`HIT_WORD_W-1:0] wide;
    wa   = a;
    wb   = b;
    wide = (wa * wb) >>> `HIT_FRAC_W;
    return wide[`HIT_WORD_W-1:0];
  endfunction

  function automatic vec3_t model_point(vec3_t o, vec3_t v, word_t t);
    vec3_t p;
    p.x = o.x + fx_mul(v.x, t);
    p.y = o.y + fx_mul(v.y, t);
    p.z = o.z + fx_mul(v.z, t);
    return p;
  endfunction

  function automatic vec3_t model_normal(vec3_t p, vec3_t c, vec3_t a, logic cyl);
    vec3_t d;
    vec3_t n;
    word_t k;
    d.x = p.x - c.x;
    d.y = p.y - c.y;
    d.z = p.z - c.z;
    k   = fx_mul(d.x, a.x) + fx_mul(d.y, a.y) + fx_mul(d.z, a.z);
    n   = d;
    if (cyl) begin
      n.x = d.x - fx_mul(a.x, k);
      n.y = d.y - fx_mul(a.y, k);
      n.z = d.z - fx_mul(a.z, k);
    end
    return n;
  endfunction

  // ~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
  // Stimulus. Each input stream offers its own beats.
  always @(posedge aclk) begin
    vec3_t p;
    logic  obj_take;
    logic  t_take;
    logic  ray_take;
    if (!rst_n) begin
      obj_valid       <= 1'b0;
      t_valid         <= 1'b0;
      ray_valid       <= 1'b0;
      hit_point_ready <= 1'b1;
      normal_ready    <= 1'b1;
      exp_valid       <= 1'b0;
    end else begin
      obj_take = obj_valid && obj_ready;
      t_take   = t_valid && t_ready;
      ray_take = ray_valid && ray_ready;
      // A transaction is one beat from each stream in the same cycle.
      if (obj_take != t_take || obj_take != ray_take) begin
        $display("Input streams were not accepted together at %0t", $time);
        input_errors <= input_errors + 1;
      end
      exp_valid <= obj_take && t_take && ray_take;
      if (obj_take && t_take && ray_take) begin
        p          = model_point(ray_origin, ray_dir, t_data);
        exp_point  <= p;
        exp_normal <= model_normal(p, obj_center, obj_axis, obj_is_cylinder);
        n_accept   <= n_accept + 1;
      end
      if (burst_check && obj_valid && !obj_ready) begin
        $display("Input stalled at %0t during the back-to-back burst", $time);
        input_errors <= input_errors + 1;
      end
      if (!obj_valid || obj_ready) begin
        if (obj_sent < target && (!rand_valid || chance(60))) begin
          obj_center      <= rand_vec(24);
          obj_axis        <= rand_vec(17);
          obj_is_cylinder <= chance(50);
          obj_valid       <= 1'b1;
          obj_sent        <= obj_sent + 1;
        end else begin
          obj_valid <= 1'b0;
        end
      end
      if (!t_valid || t_ready) begin
        if (t_sent < target && (!rand_valid || chance(60))) begin
          t_data  <= rand_word(24);
          t_valid <= 1'b1;
          t_sent  <= t_sent + 1;
        end else begin
          t_valid <= 1'b0;
        end
      end
      if (!ray_valid || ray_ready) begin
        if (ray_sent < target && (!rand_valid || chance(60))) begin
          ray_origin <= rand_vec(24);
          ray_dir    <= rand_vec(24);
          ray_valid  <= 1'b1;
          ray_sent   <= ray_sent + 1;
        end else begin
          ray_valid <= 1'b0;
        end
      end
      hit_point_ready <= !rand_ready || chance(70);
      normal_ready    <= !rand_ready || chance(70);
    end
  end

  task automatic wait_accepted(int n);
    int cnt;
    cnt = 0;
    while (!aborted && n_accept < n) begin
      if (cnt >= WAIT_LIMIT) begin
        $display("timed out waiting for input %0d", n_accept + 1);
        aborted = 1'b1;
      end else begin
        @(posedge aclk);
        cnt++;
      end
    end
  endtask

  task automatic wait_outputs(int n);
    int cnt;
    cnt = 0;
    while (!aborted && (point_count < n || normal_count < n)) begin
      if (cnt >= WAIT_LIMIT) begin
        $display("timed out waiting for output %0d", n);
        aborted = 1'b1;
      end else begin
        @(posedge aclk);
        cnt++;
      end
    end
  endtask

  initial begin
    repeat (10) @(posedge aclk);
    rst_n <= 1'b1;
    // Nothing is sent yet, so both outputs must stay idle.
    repeat (5) @(posedge aclk);
    strict_latency <= 1'b1;
    for (int i = 1; i <= ISOLATED; i++) begin
      target <= i;
      wait_accepted(i);
      wait_outputs(i);
    end
    burst_check <= 1'b1;
    target      <= ISOLATED + BURST;
    wait_accepted(ISOLATED + BURST);
    burst_check <= 1'b0;
    wait_outputs(ISOLATED + BURST);
    strict_latency <= 1'b0;
    rand_valid     <= 1'b1;
    rand_ready     <= 1'b1;
    target         <= ISOLATED + BURST + RANDOM;
    wait_accepted(ISOLATED + BURST + RANDOM);
    rand_ready <= 1'b0;
    wait_outputs(ISOLATED + BURST + RANDOM);
    @(posedge aclk);
    if (pending != 0) begin
      $display("%0d expected outputs never arrived", pending);
    end
    $display("Errors: %0d checker, %0d input; outputs: %0d hit points, %0d normals, %0d pending",
             err_count, input_errors, point_count, normal_count, pending);
    if (aborted || err_count != 0 || input_errors != 0 || pending != 0) begin
      $display("Simulation FAILED");
    end else begin
      $display("Simulation PASSED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: list.f
+incdir+verilog
verilog/hit_pkg.sv
verilog/axis_delay.sv
verilog/vec_fma.sv
verilog/vec_add.sv
verilog/vec_dot.sv
verilog/vec_scale.sv
verilog/hit_point.sv
verif/hit_point_checker.sv
verif/tb_hit_point.sv

// File: run_sim.sh
#!/bin/sh
# Build the testbench with Verilator, run it, and judge the run from its log.
rm -f sim.log
verilator --binary --timing -f list.f --top-module tb_hit_point \
  && ./obj_dir/Vtb_hit_point 2>&1 | tee sim.log \
  || { echo "build or run error"; exit 1; }
grep -q "Simulation PASSED" sim.log \
  && echo "run passed" \
  || { echo "run failed, see sim.log"; exit 1; }
